// ==== design/pov_cfg_pkg.sv ====
// ==========================================================================
// Display geometry: slices per turn, column height, period counter width
// Pixel, slice and LED index types
// ==========================================================================
package pov_cfg_pkg;

    // Angular slices in one turn, must be a power of two
    localparam int num_slices = 16;

    // LEDs stacked in one column
    localparam int leds_per_column = 8;

    // Turn period counter, saturates at all ones
    localparam int period_width = 24;

    // One pixel, one byte per colour
    // Red goes out on lane 2, green on lane 1, blue on lane 0
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // Slice number within a turn
    typedef logic [$clog2(num_slices)-1:0] slice_t;

    // Pixel number within a column
    typedef logic [$clog2(leds_per_column)-1:0] led_t;

endpackage

// ==== design/pov_bus_pkg.sv ====
// ==========================================================================
// Wishbone widths, register map and control bit positions
// ==========================================================================
package pov_bus_pkg;

    localparam int wb_addr_width = 3;
    localparam int wb_data_width = 32;

    // Register map, word addresses
    localparam logic [wb_addr_width-1:0] reg_ctrl     = 3'd0;
    localparam logic [wb_addr_width-1:0] reg_pix_addr = 3'd1;
    // Write only, auto-increments the pixel address
    localparam logic [wb_addr_width-1:0] reg_pix_data = 3'd2;
    localparam logic [wb_addr_width-1:0] reg_period   = 3'd3;
    localparam logic [wb_addr_width-1:0] reg_slice    = 3'd4;

    // CTRL fields
    localparam int ctrl_enable_bit = 0;

    // PIX_ADDR fields
    // Pixel index sits from bit 0, slice index from this bit up
    localparam int pix_slice_lsb = 8;

endpackage

// ==== design/column_if.sv ====
// ==========================================================================
// Framebuffer read channel between the column shifter and the RAM
// ==========================================================================
`timescale 1ns/1ps

interface column_if
    import pov_cfg_pkg::*;
();

    // Read request and address, from the shifter
    logic   req;
    slice_t slice;
    led_t   pixel;

    // Read result, one cycle after req
    pixel_t data;
    logic   valid;

    modport shifter (
        output req, slice, pixel,
        input  data, valid
    );

    modport ram (
        input  req, slice, pixel,
        output data, valid
    );

endinterface

// ==== design/hall_period_meter.sv ====
// ==========================================================================
// Hall input synchroniser and rising edge detector
// Turn period counter, restarted at every turn
// ==========================================================================
`timescale 1ns/1ps

module hall_period_meter
    import pov_cfg_pkg::*;
(
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    hall,
    output logic                    turn,
    output logic [period_width-1:0] period
);

    // Two stage synchroniser, then previous value for edge detect
    logic hall_s1;
    logic hall_s2;
    logic hall_d;
    logic hall_rise;

    // Cycles since the last turn pulse
    logic [period_width-1:0] count;

    assign hall_rise = hall_s2 && !hall_d;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hall_s1 <= 1'b0;
            hall_s2 <= 1'b0;
            hall_d  <= 1'b0;
            turn    <= 1'b0;
            period  <= '0;
            count   <= '0;
        end else begin
            hall_s1 <= hall;
            hall_s2 <= hall_s1;
            hall_d  <= hall_s2;

            // Registered pulse, three cycles after the raw edge
            turn <= hall_rise;

            if (hall_rise) begin
                // Count lines up with the spacing of turn pulses
                period <= count;
                count  <= period_width'(1);
            end else if (count != '1) begin
                // Stuck rotor: hold at the maximum instead of wrapping
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== design/slice_tracker.sv ====
// ==========================================================================
// Angular slice counter, slice length taken from the last turn period
// ==========================================================================
`timescale 1ns/1ps

module slice_tracker
    import pov_cfg_pkg::*;
#(
    parameter int num_slices = pov_cfg_pkg::num_slices
) (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    turn,
    input  logic [period_width-1:0] period,
    output slice_t                  slice,
    output logic                    slice_start
);

    localparam int len_shift = $clog2(num_slices);

    // Cycles per slice, fixed for the whole turn
    logic [period_width-1:0] slice_len;
    logic [period_width-1:0] len_next;
    // Cycles left in the current slice
    logic [period_width-1:0] timer;
    // Low until the first turn, so slices stay put at power-up
    logic running;

    // Very short periods still give a slice of one cycle
    assign len_next = ((period >> len_shift) == '0) ? period_width'(1)
                                                    : (period >> len_shift);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            slice       <= '0;
            slice_start <= 1'b0;
            slice_len   <= '0;
            timer       <= '0;
            running     <= 1'b0;
        end else begin
            slice_start <= 1'b0;
            if (turn) begin
                // New turn, restart at slice 0
                slice       <= '0;
                slice_start <= 1'b1;
                slice_len   <= len_next;
                timer       <= len_next - 1'b1;
                running     <= 1'b1;
            end else if (running && slice != slice_t'(num_slices - 1)) begin
                if (timer == '0) begin
                    slice       <= slice + 1'b1;
                    slice_start <= 1'b1;
                    timer       <= slice_len - 1'b1;
                end else begin
                    timer <= timer - 1'b1;
                end
            end
            // Rotor slowed down: park on the last slice until the hall edge
        end
    end

endmodule

// ==== design/display_regs.sv ====
// ==========================================================================
// Wishbone classic slave: control, pixel address and pixel data registers
// Framebuffer write port and period / slice readback
// ==========================================================================
`timescale 1ns/1ps

module display_regs
    import pov_cfg_pkg::*;
    import pov_bus_pkg::*;
#(
    parameter int num_slices      = pov_cfg_pkg::num_slices,
    parameter int leds_per_column = pov_cfg_pkg::leds_per_column
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [wb_data_width-1:0] wb_dat_w,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic                     wb_ack,
    input  logic [period_width-1:0]  period,
    input  slice_t                   slice,
    output logic                     enable,
    output logic                     ram_we,
    output slice_t                   ram_slice,
    output led_t                     ram_pixel,
    output pixel_t                   ram_data
);

    // Cycle in which a request is accepted
    // Blocked right after an ack so a held stb is not served twice
    logic   access;
    slice_t pix_slice;
    led_t   pix_pixel;

    assign access = wb_cyc && wb_stb && !wb_ack;

    // Framebuffer write straight from the bus at the accepting edge
    assign ram_we    = access && wb_we && (wb_adr == reg_pix_data);
    assign ram_slice = pix_slice;
    assign ram_pixel = pix_pixel;
    assign ram_data  = pixel_t'(wb_dat_w[$bits(pixel_t)-1:0]);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wb_ack    <= 1'b0;
            enable    <= 1'b0;
            pix_slice <= '0;
            pix_pixel <= '0;
        end else begin
            wb_ack <= access;
            if (access && wb_we) begin
                case (wb_adr)
                    reg_ctrl: enable <= wb_dat_w[ctrl_enable_bit];
                    reg_pix_addr: begin
                        pix_slice <= wb_dat_w[pix_slice_lsb +: $bits(slice_t)];
                        pix_pixel <= wb_dat_w[$bits(led_t)-1:0];
                    end
                    reg_pix_data: begin
                        // Step to the next pixel, then on to the next column
                        if (pix_pixel == led_t'(leds_per_column - 1)) begin
                            pix_pixel <= '0;
                            if (pix_slice == slice_t'(num_slices - 1))
                                pix_slice <= '0;
                            else
                                pix_slice <= pix_slice + 1'b1;
                        end else begin
                            pix_pixel <= pix_pixel + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data, stable while ack is high
    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= '0;
            case (wb_adr)
                reg_ctrl:     wb_dat_r[ctrl_enable_bit] <= enable;
                reg_pix_addr: begin
                    wb_dat_r[pix_slice_lsb +: $bits(slice_t)] <= pix_slice;
                    wb_dat_r[$bits(led_t)-1:0]                <= pix_pixel;
                end
                reg_period:   wb_dat_r[period_width-1:0] <= period;
                reg_slice:    wb_dat_r[$bits(slice_t)-1:0] <= slice;
                // PIX_DATA and unused addresses read as zero
                default: ;
            endcase
        end
    end

endmodule

// ==== design/column_ram.sv ====
// ==========================================================================
// Framebuffer: one write port from the registers, registered read port
// ==========================================================================
`timescale 1ns/1ps

module column_ram
    import pov_cfg_pkg::*;
#(
    parameter int num_slices      = pov_cfg_pkg::num_slices,
    parameter int leds_per_column = pov_cfg_pkg::leds_per_column
) (
    input  logic   clk,
    input  logic   ram_we,
    input  slice_t ram_slice,
    input  led_t   ram_pixel,
    input  pixel_t ram_data,
    column_if.ram  rd
);

    localparam int depth = num_slices * leds_per_column;

    typedef logic [$clog2(depth)-1:0] addr_t;

    // Column after column, pixel 0 of each column first
    pixel_t mem [depth];
    addr_t  waddr;
    addr_t  raddr;

    assign waddr = addr_t'(ram_slice * leds_per_column + ram_pixel);
    assign raddr = addr_t'(rd.slice * leds_per_column + rd.pixel);

    always_ff @(posedge clk) begin
        if (ram_we)
            mem[waddr] <= ram_data;
    end

    // One cycle read latency, valid marks the returned word
    always_ff @(posedge clk) begin
        rd.valid <= rd.req;
        if (rd.req)
            rd.data <= mem[raddr];
    end

endmodule

// ==== design/driver_shifter.sv ====
// ==========================================================================
// Column sequencer: pixel fetch, three lane serial shift, latch pulse
// ==========================================================================
`timescale 1ns/1ps

module driver_shifter
    import pov_cfg_pkg::*;
#(
    parameter int leds_per_column = pov_cfg_pkg::leds_per_column
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       enable,
    input  slice_t     slice,
    input  logic       slice_start,
    column_if.shifter  rd,
    output logic       sclk,
    output logic       lat,
    output logic [2:0] sin
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_shift,
        st_latch
    } state_t;

    state_t     state;
    // High for the second cycle of each bit, sclk follows it
    logic       phase;
    logic [2:0] bit_cnt;
    led_t       pix;
    slice_t     cur_slice;
    // One slice_start held back while busy
    logic       pending;
    slice_t     pend_slice;
    pixel_t     sr;
    pixel_t     shown;
    logic       start_ok;

    assign start_ok = enable && slice_start;

    // Fresh RAM word goes out directly in the first low phase
    assign shown = rd.valid ? rd.data : sr;
    assign sin   = {shown.r[7], shown.g[7], shown.b[7]};

    assign rd.req   = (state == st_fetch);
    assign rd.slice = cur_slice;
    assign rd.pixel = pix;
    assign sclk     = (state == st_shift) && phase;
    assign lat      = (state == st_latch);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= st_idle;
            phase     <= 1'b0;
            bit_cnt   <= '0;
            pix       <= '0;
            cur_slice <= '0;
            pending   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        cur_slice <= slice;
                        pix       <= led_t'(leds_per_column - 1);
                        state     <= st_fetch;
                    end
                end
                st_fetch: begin
                    phase   <= 1'b0;
                    bit_cnt <= '0;
                    state   <= st_shift;
                end
                st_shift: begin
                    phase <= !phase;
                    // End of a high phase closes one bit
                    if (phase) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            if (pix == '0) begin
                                state <= st_latch;
                            end else begin
                                pix   <= pix - 1'b1;
                                state <= st_fetch;
                            end
                        end
                    end
                end
                default: begin
                    // Latch cycle, then either the held request or idle
                    // A start in this very cycle wins over the held one
                    pending <= 1'b0;
                    if (start_ok || (pending && enable)) begin
                        cur_slice <= start_ok ? slice : pend_slice;
                        pix       <= led_t'(leds_per_column - 1);
                        state     <= st_fetch;
                    end else begin
                        state <= st_idle;
                    end
                end
            endcase

            // Busy shifting, keep only the newest request
            if (start_ok && (state == st_fetch || state == st_shift))
                pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok)
            pend_slice <= slice;
        // Load on the RAM return, move all lanes up after each high phase
        if (rd.valid) begin
            sr <= rd.data;
        end else if (state == st_shift && phase) begin
            sr.r <= sr.r << 1;
            sr.g <= sr.g << 1;
            sr.b <= sr.b << 1;
        end
    end

endmodule

// ==== design/pov_top.sv ====
// ==========================================================================
// POV display core: hall timing, slice tracking, registers, framebuffer,
// LED driver shifter
// ==========================================================================
`timescale 1ns/1ps

module pov_top
    import pov_cfg_pkg::*;
    import pov_bus_pkg::*;
#(
    parameter int num_slices      = pov_cfg_pkg::num_slices,
    parameter int leds_per_column = pov_cfg_pkg::leds_per_column
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     hall,
    // Host bus
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [wb_data_width-1:0] wb_dat_w,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic                     wb_ack,
    // LED drivers and column multiplexer
    output logic                     sclk,
    output logic                     lat,
    output logic [2:0]               sin,
    output slice_t                   col_sel
);

    logic                    turn;
    logic [period_width-1:0] period;
    slice_t                  slice;
    logic                    slice_start;
    logic                    enable;
    logic                    ram_we;
    slice_t                  ram_slice;
    led_t                    ram_pixel;
    pixel_t                  ram_data;

    column_if col_bus ();

    // Multiplexer follows the rotor position
    assign col_sel = slice;

    hall_period_meter u_hall (
        .clk    (clk),
        .nrst   (nrst),
        .hall   (hall),
        .turn   (turn),
        .period (period)
    );

    slice_tracker #(
        .num_slices (num_slices)
    ) u_slices (
        .clk         (clk),
        .nrst        (nrst),
        .turn        (turn),
        .period      (period),
        .slice       (slice),
        .slice_start (slice_start)
    );

    display_regs #(
        .num_slices      (num_slices),
        .leds_per_column (leds_per_column)
    ) u_regs (
        .clk       (clk),
        .nrst      (nrst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .period    (period),
        .slice     (slice),
        .enable    (enable),
        .ram_we    (ram_we),
        .ram_slice (ram_slice),
        .ram_pixel (ram_pixel),
        .ram_data  (ram_data)
    );

    column_ram #(
        .num_slices      (num_slices),
        .leds_per_column (leds_per_column)
    ) u_ram (
        .clk       (clk),
        .ram_we    (ram_we),
        .ram_slice (ram_slice),
        .ram_pixel (ram_pixel),
        .ram_data  (ram_data),
        .rd        (col_bus.ram)
    );

    driver_shifter #(
        .leds_per_column (leds_per_column)
    ) u_shifter (
        .clk         (clk),
        .nrst        (nrst),
        .enable      (enable),
        .slice       (slice),
        .slice_start (slice_start),
        .rd          (col_bus.shifter),
        .sclk        (sclk),
        .lat         (lat),
        .sin         (sin)
    );

endmodule

// ==== verification/pov_assert.sv ====
// ==========================================================================
// Concurrent checks on Wishbone ack, reset values, latch timing and
// slice order, bound into the display core
// ==========================================================================
`timescale 1ns/1ps

module pov_assert
    import pov_cfg_pkg::*;
(
    input logic   clk,
    input logic   nrst,
    input logic   wb_cyc,
    input logic   wb_stb,
    input logic   wb_ack,
    input logic   sclk,
    input logic   lat,
    input slice_t col_sel
);

    // Number of failed assertions so far
    int fail_count = 0;

    // Outputs quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !nrst |-> !sclk && !lat && !wb_ack)
        else begin
            fail_count++;
            $error("sclk, lat or ack active during reset");
        end

    // Ack only inside a bus cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (!nrst)
        wb_ack |-> wb_cyc && wb_stb)
        else begin
            fail_count++;
            $error("ack without cyc and stb");
        end

    // Never two ack cycles in a row
    ack_single: assert property (@(posedge clk) disable iff (!nrst)
        wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("ack held for more than one cycle");
        end

    lat_sclk_low: assert property (@(posedge clk) disable iff (!nrst)
        lat |-> !sclk)
        else begin
            fail_count++;
            $error("lat high together with sclk");
        end

    lat_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
        lat |=> !lat)
        else begin
            fail_count++;
            $error("lat pulse longer than one cycle");
        end

    // Latch in the cycle right after the last sclk high phase
    lat_after_shift: assert property (@(posedge clk) disable iff (!nrst)
        lat |-> $past(sclk))
        else begin
            fail_count++;
            $error("lat not after the last sclk pulse");
        end

    // Multiplexer steps up by one or restarts at slice 0
    slice_order: assert property (@(posedge clk) disable iff (!nrst)
        (col_sel != $past(col_sel)) |->
            (col_sel == slice_t'($past(col_sel) + 1'b1)) || (col_sel == '0))
        else begin
            fail_count++;
            $error("col_sel skipped a slice");
        end

endmodule

bind pov_top pov_assert u_chk (
    .clk     (clk),
    .nrst    (nrst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .sclk    (sclk),
    .lat     (lat),
    .col_sel (col_sel)
);

// ==== verification/pov_tb.sv ====
// ==========================================================================
// Testbench for the POV display core: Wishbone host, hall stimulus,
// serial column capture and compare, watchdog
// ==========================================================================
`timescale 1ns/1ps

module pov_tb
    import pov_cfg_pkg::*;
    import pov_bus_pkg::*;
();

    // 160 cycles per slice leaves room for one full column shift
    localparam int hall_period  = num_slices * 160;
    localparam int col_bits     = 8 * leds_per_column;
    localparam int turns_budget = 8;
    localparam longint timeout_ns = longint'(turns_budget * hall_period + 3000) * 10;

    logic                     clk;
    logic                     nrst;
    logic                     hall;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic                     wb_ack;
    logic                     sclk;
    logic                     lat;
    logic [2:0]               sin;
    slice_t                   col_sel;

    // Pixels as written by the host, slice major
    pixel_t     ref_mem [num_slices * leds_per_column];
    logic [2:0] cap_bits [col_bits];
    integer     seed = 62136;
    logic       hall_run = 1'b0;
    int         ack_count = 0;
    int         cap_n = 0;
    int         sclk_count = 0;
    int         lat_count = 0;
    int         columns_checked = 0;
    int         turns_checked = 0;
    int         slice_steps = 0;
    logic       slice_armed = 1'b0;
    slice_t     last_sel = '0;

    pov_top #(
        .num_slices      (num_slices),
        .leds_per_column (leds_per_column)
    ) DUT (
        .clk (clk), .nrst (nrst), .hall (hall),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .sclk (sclk), .lat (lat), .sin (sin), .col_sel (col_sel)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic value_mismatch(input string what);
        abort_run($sformatf("CHECK FAILED at %0d ns: %s", $time, what));
    endtask

    // Ends on the edge that closes the ack cycle
    task automatic wait_for_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 16)
                abort_run("Wishbone access was never acknowledged");
        end while (wb_ack !== 1'b1);
    endtask

    task automatic end_access(input int acks_before);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // One more edge to catch a second ack
        @(posedge clk);
        #1;
        if (ack_count != acks_before + 1)
            value_mismatch($sformatf("%0d acks for one access", ack_count - acks_before));
    endtask

    task automatic wb_write(input logic [wb_addr_width-1:0] adr,
                            input logic [wb_data_width-1:0] data);
        int acks_before;
        acks_before = ack_count;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_for_ack();
        end_access(acks_before);
    endtask

    task automatic wb_read_check(input logic [wb_addr_width-1:0] adr,
                                 input logic [wb_data_width-1:0] expected);
        int acks_before;
        logic [wb_data_width-1:0] got;
        acks_before = ack_count;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_for_ack();
        got = wb_dat_r;
        end_access(acks_before);
        if (got !== expected)
            value_mismatch($sformatf("register %0d read %h, expected %h", adr, got, expected));
    endtask

    // Red, green and blue bit b, lanes 2 down to 0
    function automatic logic [2:0] lanes_of(input pixel_t px, input int b);
        return {px.r[b], px.g[b], px.b[b]};
    endfunction

    // Pixels from the top index down, each byte MSB first
    task automatic compare_column(input slice_t s);
        int p;
        int b;
        logic [2:0] exp;
        if (cap_n != col_bits)
            value_mismatch($sformatf("slice %0d shifted %0d bits", s, cap_n));
        for (int k = 0; k < col_bits; k++) begin
            p   = leds_per_column - 1 - k / 8;
            b   = 7 - k % 8;
            exp = lanes_of(ref_mem[s * leds_per_column + p], b);
            if (cap_bits[k] !== exp)
                value_mismatch($sformatf("slice %0d pixel %0d bit %0d: sin %b, expected %b",
                                         s, p, b, cap_bits[k], exp));
        end
        columns_checked++;
    endtask

    // Outputs sampled at the clock edge, before the DUT updates them
    always @(posedge clk) begin
        if (wb_ack === 1'b1)
            ack_count++;
        if (nrst === 1'b1) begin
            if (sclk === 1'b1) begin
                sclk_count++;
                if (cap_n < col_bits)
                    cap_bits[cap_n] = sin;
                cap_n++;
            end
            if (lat === 1'b1) begin
                lat_count++;
                compare_column(col_sel);
                cap_n = 0;
            end
        end
    end

    // Slice walk per turn, counted from the first return to 0
    always @(posedge clk) begin
        if (nrst === 1'b1 && col_sel !== last_sel) begin
            if (col_sel == '0) begin
                if (slice_armed && slice_steps != num_slices - 1)
                    value_mismatch($sformatf("turn had %0d slice steps", slice_steps));
                if (slice_armed)
                    turns_checked++;
                slice_armed = 1'b1;
                slice_steps = 0;
            end else if (col_sel == slice_t'(last_sel + 1'b1)) begin
                slice_steps++;
            end else begin
                value_mismatch($sformatf("col_sel went from %0d to %0d", last_sel, col_sel));
            end
            last_sel = col_sel;
        end
    end

    always @(posedge clk) begin
        if (DUT.u_chk.fail_count != 0)
            abort_run("A bus or driver timing assertion failed");
    end

    // Square wave hall input, edges 1 ns after the clock
    initial begin
        hall = 1'b0;
        wait (hall_run);
        forever begin
            repeat (hall_period / 2) @(posedge clk);
            #1 hall = ~hall;
        end
    end

    initial begin
        #(timeout_ns);
        abort_run($sformatf("Timeout: the run did not finish within %0d ns", timeout_ns));
    end

    initial begin
        nrst     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;

        // Reset held for 5 cycles, outputs must stay low
        repeat (5) begin
            @(posedge clk);
            if (sclk !== 1'b0 || lat !== 1'b0 || wb_ack !== 1'b0)
                value_mismatch("sclk, lat or wb_ack not low in reset");
        end
        #1 nrst = 1'b1;
        @(posedge clk);
        if (sclk !== 1'b0 || lat !== 1'b0 || wb_ack !== 1'b0)
            value_mismatch("sclk, lat or wb_ack not low after reset");

        // Register readback
        wb_write(reg_ctrl, 32'h1);
        wb_read_check(reg_ctrl, 32'h1);
        wb_write(reg_ctrl, 32'h0);
        wb_read_check(reg_ctrl, 32'h0);
        wb_write(reg_pix_addr, (32'd5 << pix_slice_lsb) | 32'd3);
        wb_read_check(reg_pix_addr, (32'd5 << pix_slice_lsb) | 32'd3);

        // Whole framebuffer through the auto-incrementing data register
        wb_write(reg_pix_addr, 32'h0);
        for (int i = 0; i < num_slices * leds_per_column; i++) begin
            ref_mem[i] = pixel_t'($random(seed));
            wb_write(reg_pix_data, 32'(ref_mem[i]));
        end
        // Address wrapped back to slice 0, pixel 0
        wb_read_check(reg_pix_addr, 32'h0);

        // Two turns with the drivers disabled
        hall_run = 1'b1;
        repeat (3) @(posedge hall);
        repeat (5) @(posedge clk);
        wb_read_check(reg_period, 32'(hall_period));
        if (sclk_count != 0 || lat_count != 0)
            value_mismatch("sclk or lat seen while disabled");

        // Enabled turns, columns compared at every lat
        wb_write(reg_ctrl, 32'h1);
        repeat (3) @(posedge hall);
        repeat (10) @(posedge clk);
        #1;
        if (columns_checked < 2 * num_slices)
            value_mismatch($sformatf("only %0d columns latched", columns_checked));
        if (turns_checked < 3)
            value_mismatch($sformatf("only %0d full turns tracked", turns_checked));

        if (DUT.u_chk.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("A bus or driver timing assertion failed");
        end
    end

endmodule

// ==== pov_display.f ====
design/pov_cfg_pkg.sv
design/pov_bus_pkg.sv
design/column_if.sv
design/hall_period_meter.sv
design/slice_tracker.sv
design/display_regs.sv
design/column_ram.sv
design/driver_shifter.sv
design/pov_top.sv
verification/pov_assert.sv
verification/pov_tb.sv

// ==== Bender.yml ====
package:
  name: pov_display

sources:
  - design/pov_cfg_pkg.sv
  - design/pov_bus_pkg.sv
  - design/column_if.sv
  - design/hall_period_meter.sv
  - design/slice_tracker.sv
  - design/display_regs.sv
  - design/column_ram.sv
  - design/driver_shifter.sv
  - design/pov_top.sv
  - target: test
    files:
      - verification/pov_assert.sv
      - verification/pov_tb.sv
